// ==== include/rank_filter_defs.svh ====
`ifndef RANK_FILTER_DEFS_SVH
`define RANK_FILTER_DEFS_SVH

// width of one unsigned sample
`define SAMPLE_W 8

// the sorter network is built for exactly five taps
`define WIN_LEN 5

`define RANK_W 3

`endif

// ==== rtl/sample_pkg.sv ====
`default_nettype none

`include "rank_filter_defs.svh"

package sample_pkg;

  typedef logic [`SAMPLE_W-1:0] sample_t;

  // tap[0] holds the newest sample, tap[WIN_LEN-1] the oldest
  typedef struct packed {
    sample_t [`WIN_LEN-1:0] tap;
  } window_t;

  // one window in ascending order
  typedef struct packed {
    sample_t min;
    sample_t second;
    sample_t mid;
    sample_t fourth;
    sample_t max;
  } sorted_t;

endpackage

`default_nettype wire

// ==== rtl/rank_pkg.sv ====
`default_nettype none

`include "rank_filter_defs.svh"

package rank_pkg;

  typedef enum logic [`RANK_W-1:0] {
    rank_min    = 3'd0,
    rank_second = 3'd1,
    rank_mid    = 3'd2,
    rank_fourth = 3'd3,
    rank_max    = 3'd4
  } rank_e;

  // sideband that follows a window down the sort pipeline
  typedef struct packed {
    logic  valid;
    rank_e rank;
  } rank_tag_t;

endpackage

`default_nettype wire

// ==== rtl/sort3_network.sv ====
`timescale 1ns/10ps
`default_nettype none

module sort3_network (
  input  sample_pkg::sample_t a,
  input  sample_pkg::sample_t b,
  input  sample_pkg::sample_t c,
  output sample_pkg::sample_t max,
  output sample_pkg::sample_t med,
  output sample_pkg::sample_t min
);
  import sample_pkg::*;

  sample_t hi_ab;
  sample_t lo_ab;
  sample_t lo_hc;

  // order a and b first
  assign hi_ab = (a > b) ? a : b;
  assign lo_ab = (a > b) ? b : a;

  // the larger of a and b competes with c for the top
  assign max   = (hi_ab > c) ? hi_ab : c;
  assign lo_hc = (hi_ab > c) ? c : hi_ab;

  // what is left splits into middle and bottom
  assign med = (lo_ab > lo_hc) ? lo_ab : lo_hc;
  assign min = (lo_ab > lo_hc) ? lo_hc : lo_ab;

endmodule

`default_nettype wire

// ==== rtl/window_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rank_filter_defs.svh"

module window_capture (
  input  logic                clk,
  input  logic                rst_n,
  input  sample_pkg::sample_t sample_in,
  input  logic                sample_valid,
  input  logic                flush,
  input  logic [`RANK_W-1:0]  rank_code,
  output sample_pkg::window_t window,
  output rank_pkg::rank_tag_t win_tag
);
  import sample_pkg::*;
  import rank_pkg::*;

  localparam int FILL_W = $clog2(`WIN_LEN + 1);

  logic [FILL_W-1:0] fill;
  logic [FILL_W-1:0] fill_base;
  logic [FILL_W-1:0] fill_next;
  rank_e             rank_dec;

  // a flush drops the old fill before the current sample is counted
  assign fill_base = flush ? '0 : fill;

  always_comb begin
    fill_next = fill_base;
    if (sample_valid && fill_base != FILL_W'(`WIN_LEN)) begin
      fill_next = fill_base + 1'b1;
    end
  end

  always_comb begin
    case (rank_code)
      3'd0:    rank_dec = rank_min;
      3'd1:    rank_dec = rank_second;
      3'd3:    rank_dec = rank_fourth;
      3'd4:    rank_dec = rank_max;
      default: rank_dec = rank_mid; // codes 5 to 7 fall back to the median
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      window  <= '0;
      win_tag <= '0;
      fill    <= '0;
    end else begin
      fill          <= fill_next;
      win_tag.valid <= sample_valid && (fill_next == FILL_W'(`WIN_LEN));
      if (sample_valid) begin
        window.tap   <= {window.tap[`WIN_LEN-2:0], sample_in}; // newest enters at tap 0
        win_tag.rank <= rank_dec;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sort5_pipeline.sv ====
`timescale 1ns/10ps
`default_nettype none

module sort5_pipeline (
  input  logic                clk,
  input  logic                rst_n,
  input  sample_pkg::window_t window,
  input  rank_pkg::rank_tag_t win_tag,
  output sample_pkg::sorted_t sorted,
  output rank_pkg::rank_tag_t sort_tag
);
  import sample_pkg::*;
  import rank_pkg::*;

  sample_t sn1_max, sn1_med, sn1_min;
  sample_t sn2_max, sn2_med, sn2_min;
  sample_t sn3_max, sn3_med, sn3_min;
  sample_t sn4_max, sn4_med, sn4_min;

  sample_t   p1_tap3, p1_tap4, p1_max, p1_med, p1_min;
  rank_tag_t p1_tag;
  sample_t   p2_max, p2_med, p2_min, p2_med1, p2_min1;
  rank_tag_t p2_tag;
  sample_t   p3_max, p3_med, p3_min, p3_min1, p3_max_o;
  rank_tag_t p3_tag;

  // three newest taps are sorted straight off the window register
  sort3_network i_sn1 (
    .a   (window.tap[0]),
    .b   (window.tap[1]),
    .c   (window.tap[2]),
    .max (sn1_max),
    .med (sn1_med),
    .min (sn1_min)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p1_tap3 <= '0;
      p1_tap4 <= '0;
      p1_max  <= '0;
      p1_med  <= '0;
      p1_min  <= '0;
      p1_tag  <= '0;
    end else begin
      p1_tap3 <= window.tap[3];
      p1_tap4 <= window.tap[4];
      p1_max  <= sn1_max;
      p1_med  <= sn1_med;
      p1_min  <= sn1_min;
      p1_tag  <= win_tag;
    end
  end

  // overall max comes out of this merge
  sort3_network i_sn2 (
    .a   (p1_max),
    .b   (p1_tap3),
    .c   (p1_tap4),
    .max (sn2_max),
    .med (sn2_med),
    .min (sn2_min)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p2_max  <= '0;
      p2_med  <= '0;
      p2_min  <= '0;
      p2_med1 <= '0;
      p2_min1 <= '0;
      p2_tag  <= '0;
    end else begin
      p2_max  <= sn2_max;
      p2_med  <= sn2_med;
      p2_min  <= sn2_min;
      p2_med1 <= p1_med;
      p2_min1 <= p1_min;
      p2_tag  <= p1_tag;
    end
  end

  sort3_network i_sn3 (
    .a   (p2_med1),
    .b   (p2_med),
    .c   (p2_min),
    .max (sn3_max),
    .med (sn3_med),
    .min (sn3_min)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p3_max   <= '0;
      p3_med   <= '0;
      p3_min   <= '0;
      p3_min1  <= '0;
      p3_max_o <= '0;
      p3_tag   <= '0;
    end else begin
      p3_max   <= sn3_max; // second largest is settled here
      p3_med   <= sn3_med;
      p3_min   <= sn3_min;
      p3_min1  <= p2_min1;
      p3_max_o <= p2_max;
      p3_tag   <= p2_tag;
    end
  end

  // the low three resolve after the last register
  sort3_network i_sn4 (
    .a   (p3_min1),
    .b   (p3_med),
    .c   (p3_min),
    .max (sn4_max),
    .med (sn4_med),
    .min (sn4_min)
  );

  assign sorted.min    = sn4_min;
  assign sorted.second = sn4_med;
  assign sorted.mid    = sn4_max;
  assign sorted.fourth = p3_max;
  assign sorted.max    = p3_max_o;
  assign sort_tag      = p3_tag;

endmodule

`default_nettype wire

// ==== rtl/rank_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module rank_select (
  input  logic                clk,
  input  logic                rst_n,
  input  sample_pkg::sorted_t sorted,
  input  rank_pkg::rank_tag_t sort_tag,
  output sample_pkg::sample_t filt_out,
  output logic                out_valid
);
  import sample_pkg::*;
  import rank_pkg::*;

  sample_t pick;

  always_comb begin
    case (sort_tag.rank)
      rank_min:    pick = sorted.min;
      rank_second: pick = sorted.second;
      rank_fourth: pick = sorted.fourth;
      rank_max:    pick = sorted.max;
      default:     pick = sorted.mid;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      filt_out  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= sort_tag.valid;
      if (sort_tag.valid) begin
        filt_out <= pick; // holds the last result between strobes
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rank_filter_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rank_filter_defs.svh"

module rank_filter_top (
  input  logic                clk,
  input  logic                rst_n,
  input  sample_pkg::sample_t sample_in,
  input  logic                sample_valid,
  input  logic [`RANK_W-1:0]  rank_code,
  input  logic                flush,
  output sample_pkg::sample_t filt_out,
  output logic                out_valid
);
  import sample_pkg::*;
  import rank_pkg::*;

  window_t   window;
  rank_tag_t win_tag;
  sorted_t   sorted;
  rank_tag_t sort_tag;

  // decode
  window_capture i_window_capture (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_in    (sample_in),
    .sample_valid (sample_valid),
    .flush        (flush),
    .rank_code    (rank_code),
    .window       (window),
    .win_tag      (win_tag)
  );

  // execute stage is three cycles deep
  sort5_pipeline i_sort5_pipeline (
    .clk      (clk),
    .rst_n    (rst_n),
    .window   (window),
    .win_tag  (win_tag),
    .sorted   (sorted),
    .sort_tag (sort_tag)
  );

  rank_select i_rank_select (
    .clk       (clk),
    .rst_n     (rst_n),
    .sorted    (sorted),
    .sort_tag  (sort_tag),
    .filt_out  (filt_out),
    .out_valid (out_valid)
  );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1; // released on an edge like any other input
  end

endmodule

`default_nettype wire

// ==== verif/rank_filter_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module rank_filter_properties (
  input logic                clk,
  input logic                rst_n,
  input logic                out_valid,
  input rank_pkg::rank_tag_t win_tag,
  input rank_pkg::rank_tag_t sort_tag,
  input sample_pkg::sorted_t sorted
);

  int fail_count = 0; // summed into the testbench error count at the end of the run

  // one edge into reset the result strobe has to be low
  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else begin
      $error("out_valid high while rst_n is low");
      fail_count++;
    end

  // sort pipeline plus result register is four cycles
  a_window_to_result: assert property (@(posedge clk) disable iff (!rst_n)
    win_tag.valid |-> ##4 out_valid)
    else begin
      $error("window issued without a result four cycles later");
      fail_count++;
    end

  a_sorted_order: assert property (@(posedge clk) disable iff (!rst_n)
    sort_tag.valid |-> (sorted.min <= sorted.second) && (sorted.second <= sorted.mid) &&
                       (sorted.mid <= sorted.fourth) && (sorted.fourth <= sorted.max))
    else begin
      $error("sorter output is not in ascending order");
      fail_count++;
    end

endmodule

bind rank_filter_top rank_filter_properties i_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .out_valid (out_valid),
  .win_tag   (win_tag),
  .sort_tag  (sort_tag),
  .sorted    (sorted)
);

`default_nettype wire

// ==== verif/rank_filter_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rank_filter_defs.svh"

module rank_filter_tb;
  import sample_pkg::*;

  localparam int LATENCY     = 5;  // drive edge of a completing sample to out_valid
  localparam int DRAIN_MAX   = 10; // idle cycles a test may spend on its last results
  localparam int STIM_CYCLES = 5 + 200 + 100 + 40 + 60 + 150;
  localparam int CYCLE_LIMIT = 4 + STIM_CYCLES + 6 * DRAIN_MAX + 20;

  logic               clk;
  logic               rst_n;
  sample_t            sample_in;
  logic               sample_valid;
  logic [`RANK_W-1:0] rank_code;
  logic               flush;
  sample_t            filt_out;
  logic               out_valid;

  sample_t                            exp_q[$];
  int                                 due_q[$];
  sample_t                            exp_val;
  int                                 exp_due;
  logic [`WIN_LEN-1:0][`SAMPLE_W-1:0] hist;
  int                                 fill;
  int                                 cycles;
  int                                 errors;
  int                                 checks;
  int                                 tests;

  tb_clock_gen #(.PERIOD(100), .RST_CYCLES(4)) i_clock_gen (.clk(clk), .rst_n(rst_n));

  rank_filter_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_in    (sample_in),
    .sample_valid (sample_valid),
    .rank_code    (rank_code),
    .flush        (flush),
    .filt_out     (filt_out),
    .out_valid    (out_valid)
  );

  // insertion sort on a copy of the window, then pick by rank
  function automatic sample_t ref_pick(input logic [`WIN_LEN-1:0][`SAMPLE_W-1:0] win,
                                       input logic [`RANK_W-1:0] code);
    sample_t s[`WIN_LEN];
    sample_t t;
    int      j;
    for (int i = 0; i < `WIN_LEN; i++) begin
      s[i] = win[i];
    end
    for (int i = 1; i < `WIN_LEN; i++) begin
      t = s[i];
      j = i - 1;
      while (j >= 0 && s[j] > t) begin
        s[j + 1] = s[j];
        j--;
      end
      s[j + 1] = t;
    end
    return (code <= 3'd4) ? s[code] : s[2]; // codes 5 to 7 read as the median
  endfunction

  // drive one cycle of inputs and track the window the DUT will see
  task automatic apply(input sample_t s, input logic v, input logic [`RANK_W-1:0] code,
                       input logic f);
    @(posedge clk);
    sample_in    <= s;
    sample_valid <= v;
    rank_code    <= code;
    flush        <= f;
    if (f) begin
      fill = 0;
    end
    if (v) begin
      hist = {hist[`WIN_LEN-2:0], s};
      if (fill < `WIN_LEN) begin
        fill++;
      end
      if (fill == `WIN_LEN) begin
        exp_q.push_back(ref_pick(hist, code));
        due_q.push_back(cycles + 1 + LATENCY); // cycles has not yet counted this edge
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_start, input int chk_start);
    int waited;
    waited = 0;
    apply('0, 1'b0, '0, 1'b0);
    while (exp_q.size() != 0 && waited < DRAIN_MAX - 3) begin
      @(posedge clk);
      waited++;
    end
    repeat (2) @(posedge clk); // gives a stray out_valid time to show up
    if (exp_q.size() != 0) begin
      $display("test %s: %0d expected results never came out", name, exp_q.size());
      errors++;
      exp_q.delete();
      due_q.delete();
    end
    tests++;
    $display("test %s finished: %0d checks, %0d errors", name, checks - chk_start,
             errors - err_start);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // outputs are read at the falling edge where they are settled
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid high at cycle %0d with no result expected", cycles);
        errors++;
      end else begin
        exp_val = exp_q.pop_front();
        exp_due = due_q.pop_front();
        checks++;
        if (cycles != exp_due) begin
          $display("out_valid came at cycle %0d instead of cycle %0d", cycles, exp_due);
          errors++;
        end
        if (filt_out !== exp_val) begin
          $display("error filt_out expected %h actual %h", exp_val, filt_out);
          errors++;
        end
      end
    end
  end

  initial begin
    int                 err0;
    int                 chk0;
    sample_t            s;
    logic [`RANK_W-1:0] code;
    sample_in    = '0;
    sample_valid = 1'b0;
    rank_code    = '0;
    flush        = 1'b0;
    hist         = '0;
    fill         = 0;
    void'($urandom(32'h2243_6a2a));
    @(posedge clk);
    while (!rst_n) @(posedge clk);

    err0 = errors;
    chk0 = checks;
    for (int i = 0; i < 5; i++) begin
      apply(sample_t'($urandom), 1'b1, 3'd2, 1'b0);
    end
    finish_test("fill", err0, chk0);

    err0 = errors;
    chk0 = checks;
    for (int i = 0; i < 200; i++) begin
      apply(sample_t'($urandom), 1'b1, 3'd2, i == 0);
    end
    finish_test("back_to_back_median", err0, chk0);

    err0 = errors;
    chk0 = checks;
    for (int i = 0; i < 100; i++) begin
      apply(sample_t'($urandom), 1'b1, 3'($urandom_range(4, 0)), 1'b0);
    end
    finish_test("every_rank", err0, chk0);

    err0 = errors;
    chk0 = checks;
    for (int i = 0; i < 40; i++) begin
      apply(sample_t'($urandom), 1'b1, 3'($urandom_range(7, 5)), 1'b0);
    end
    finish_test("illegal_rank", err0, chk0);

    // flush alone at 10, flush with a sample at 25, 27 and 40
    err0 = errors;
    chk0 = checks;
    for (int i = 0; i < 60; i++) begin
      code = 3'($urandom_range(7, 0));
      apply(sample_t'($urandom), i != 10, code, i == 10 || i == 25 || i == 27 || i == 40);
    end
    finish_test("flush", err0, chk0);

    err0 = errors;
    chk0 = checks;
    for (int i = 0; i < 150; i++) begin
      case ($urandom_range(3, 0))
        0:       s = 8'h00;
        1:       s = 8'hff;
        default: s = 8'h40 + sample_t'($urandom_range(1, 0)); // a narrow range gives duplicates
      endcase
      apply(s, 1'($urandom_range(1, 0)), 3'($urandom_range(7, 0)), 1'b0);
    end
    finish_test("sparse_extremes", err0, chk0);

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, checks,
             errors, i_dut.i_props.fail_count);
    errors = errors + i_dut.i_props.fail_count;
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
rtl/sample_pkg.sv
rtl/rank_pkg.sv
rtl/sort3_network.sv
rtl/window_capture.sv
rtl/sort5_pipeline.sv
rtl/rank_select.sv
rtl/rank_filter_top.sv
verif/tb_clock_gen.sv
verif/rank_filter_properties.sv
verif/rank_filter_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rank_filter_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_FLAGS ?= +verilator+error+limit+1000

FAIL_MSG = Done: errors found
PASS_MSG = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
